/* hw/lin_consts.svh */
// gain/offset stage constants
// widths, register map and reset values shared by the package and the RTL

`ifndef LIN_CONSTS_SVH
`define LIN_CONSTS_SVH

// datapath widths
`define LIN_IN_W    14  // input sample
`define LIN_OUT_W   14  // output sample
`define LIN_GAIN_W  16  // gain, Q2.14
`define LIN_OFS_W   14  // offset
`define LIN_REG_W   32  // register data
`define LIN_ADDR_W  2   // register address

// register map
`define LIN_ADDR_GAIN    0
`define LIN_ADDR_OFS     1
`define LIN_ADDR_SATCNT  2  // write clears

// reset values
`define LIN_GAIN_RST  16384  // unity in Q2.14
`define LIN_OFS_RST   0

`endif

/* hw/lin_pkg.sv */
// gain/offset stage types
// sample, coefficient and register port types built on the shared widths

`default_nettype none

`include "lin_consts.svh"

package lin_pkg;

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////

  typedef logic signed [`LIN_IN_W-1:0]   sample_in_t;   // adc sample
  typedef logic signed [`LIN_OUT_W-1:0]  sample_out_t;  // saturated result
  typedef logic signed [`LIN_GAIN_W-1:0] gain_t;        // Q2.14
  typedef logic signed [`LIN_OFS_W-1:0]  offset_t;

  //////////////////////////////////////////////////
  // register port
  //////////////////////////////////////////////////

  typedef logic [`LIN_ADDR_W-1:0] reg_addr_t;
  typedef logic [`LIN_REG_W-1:0]  reg_dat_t;
  typedef logic [`LIN_REG_W-1:0]  sat_cnt_t;  // unsigned, sticks at max

endpackage

`default_nettype wire

/* hw/lin_regs.sv */
// gain/offset register block
// holds gain and offset for the transform pipeline and counts
// clipped output samples, single-cycle write and combinational read

`default_nettype none

`include "lin_consts.svh"

module lin_regs (
  input  wire                sti,
  input  wire                rst,
  // register port
  input  wire                reg_we,
  input  wire lin_pkg::reg_addr_t reg_addr,
  input  wire lin_pkg::reg_dat_t  reg_wdat,
  output lin_pkg::reg_dat_t  reg_rdat,
  // to the pipeline
  output lin_pkg::gain_t     cfg_gain,
  output lin_pkg::offset_t   cfg_ofs,
  // from the pipeline
  input  wire                sat_evt
);

  import lin_pkg::*;

  sat_cnt_t sat_cnt;  // clipped sample count
  logic     cnt_clr;  // write to count address
  logic     cnt_max;  // counter saturated

  //////////////////////////////////////////////////
  // configuration
  //////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (rst) begin
      cfg_gain <= gain_t'(`LIN_GAIN_RST);  // unity
      cfg_ofs  <= offset_t'(`LIN_OFS_RST);
    end else if (reg_we) begin
      case (reg_addr)
        reg_addr_t'(`LIN_ADDR_GAIN): cfg_gain <= reg_wdat[`LIN_GAIN_W-1:0];
        reg_addr_t'(`LIN_ADDR_OFS):  cfg_ofs  <= reg_wdat[`LIN_OFS_W-1:0];
        default: ;  // count clear handled below
      endcase
    end
  end

  //////////////////////////////////////////////////
  // saturation counter
  //////////////////////////////////////////////////

  assign cnt_clr = reg_we && (reg_addr == reg_addr_t'(`LIN_ADDR_SATCNT));
  assign cnt_max = &sat_cnt;

  always_ff @(posedge sti) begin
    if (rst) begin
      sat_cnt <= '0;
    end else if (cnt_clr) begin
      sat_cnt <= '0;  // clear beats a same-cycle event
    end else if (sat_evt && !cnt_max) begin
      sat_cnt <= sat_cnt + 1'b1;  // holds at all ones
    end
  end

  //////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////

  always_comb begin
    case (reg_addr)
      reg_addr_t'(`LIN_ADDR_GAIN):
        reg_rdat = {{(`LIN_REG_W-`LIN_GAIN_W){cfg_gain[`LIN_GAIN_W-1]}}, cfg_gain};
      reg_addr_t'(`LIN_ADDR_OFS):
        reg_rdat = {{(`LIN_REG_W-`LIN_OFS_W){cfg_ofs[`LIN_OFS_W-1]}}, cfg_ofs};
      reg_addr_t'(`LIN_ADDR_SATCNT):
        reg_rdat = sat_cnt;  // same width, no extension
      default:
        reg_rdat = '0;  // unmapped
    endcase
  end

  // a write must decode to a known register
  a_we_addr_known: assert property (
    @(posedge sti) disable iff (rst)
    reg_we |-> !$isunknown(reg_addr)
  );

endmodule

`default_nettype wire

/* hw/lin_xform.sv */
// gain/offset transform pipeline
// out = sat(floor(in * gain / 2^14) + offset), three register stages
// multiply, shift/add, saturate with valid/ready flow and full back-pressure

`default_nettype none

`include "lin_consts.svh"

module lin_xform (
  input  wire                      sti,
  input  wire                      rst,
  // input stream
  input  wire lin_pkg::sample_in_t in_dat,
  input  wire                      in_vld,
  output logic                     in_rdy,
  // output stream
  output lin_pkg::sample_out_t     out_dat,
  output logic                     out_vld,
  input  wire                      out_rdy,
  // configuration
  input  wire lin_pkg::gain_t      cfg_gain,
  input  wire lin_pkg::offset_t    cfg_ofs,
  // status
  output logic                     sat_evt
);

  import lin_pkg::*;

  localparam int unsigned IN_W   = `LIN_IN_W;
  localparam int unsigned OUT_W  = `LIN_OUT_W;
  localparam int unsigned GAIN_W = `LIN_GAIN_W;
  localparam int unsigned OFS_W  = `LIN_OFS_W;
  localparam int unsigned SHIFT  = GAIN_W - 2;     // Q2.14 binary point
  localparam int unsigned PROD_W = IN_W + GAIN_W;  // full product
  // shifted product or offset, whichever is wider, plus a carry bit
  localparam int unsigned SUM_W  = ((PROD_W - SHIFT) > OFS_W ? (PROD_W - SHIFT) : OFS_W) + 1;

  // stage 1, multiply
  logic                    s1_vld;
  logic                    s1_rdy;
  logic signed [PROD_W-1:0] s1_prod;

  // stage 2, shift and add
  logic                    s2_vld;
  logic                    s2_rdy;
  logic signed [SUM_W-1:0] s2_sum;
  logic signed [SUM_W-1:0] shf_ext;  // floored product
  logic signed [SUM_W-1:0] ofs_ext;  // sign-extended offset

  // stage 3, saturate
  logic                    s3_rdy;
  logic                    s3_ld;
  logic                    s2_ovf;   // sum outside output range
  sample_out_t             sat_val;  // clip level for s2_sum sign

  //////////////////////////////////////////////////
  // ready chain
  //////////////////////////////////////////////////

  assign s3_rdy = !out_vld || out_rdy;  // output slot free or draining
  assign s2_rdy = !s2_vld  || s3_rdy;
  assign s1_rdy = !s1_vld  || s2_rdy;
  assign in_rdy = s1_rdy;

  //////////////////////////////////////////////////
  // stage 1, multiply
  //////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (rst) begin
      s1_vld <= 1'b0;
    end else if (s1_rdy) begin
      s1_vld <= in_vld;
    end
  end

  always_ff @(posedge sti) begin
    if (in_vld && s1_rdy) begin
      s1_prod <= in_dat * cfg_gain;  // signed, full width
    end
  end

  //////////////////////////////////////////////////
  // stage 2, shift and add
  //////////////////////////////////////////////////

  // arithmetic shift floors, result fits SUM_W by construction
  assign shf_ext = SUM_W'(s1_prod >>> SHIFT);
  assign ofs_ext = SUM_W'(cfg_ofs);

  always_ff @(posedge sti) begin
    if (rst) begin
      s2_vld <= 1'b0;
    end else if (s2_rdy) begin
      s2_vld <= s1_vld;
    end
  end

  always_ff @(posedge sti) begin
    if (s1_vld && s2_rdy) begin
      s2_sum <= shf_ext + ofs_ext;  // no overflow, carry bit spare
    end
  end

  //////////////////////////////////////////////////
  // stage 3, saturate
  //////////////////////////////////////////////////

  // in range when all bits above the output sign match it
  assign s2_ovf  = s2_sum[SUM_W-1:OUT_W-1] != {(SUM_W-OUT_W+1){s2_sum[SUM_W-1]}};
  assign sat_val = s2_sum[SUM_W-1] ? {1'b1, {(OUT_W-1){1'b0}}}   // -8192
                                   : {1'b0, {(OUT_W-1){1'b1}}};  // 8191
  assign s3_ld   = s2_vld && s3_rdy;

  always_ff @(posedge sti) begin
    if (rst) begin
      out_vld <= 1'b0;
      sat_evt <= 1'b0;
    end else begin
      if (s3_rdy) begin
        out_vld <= s2_vld;
      end
      sat_evt <= s3_ld && s2_ovf;  // one pulse per clipped sample
    end
  end

  always_ff @(posedge sti) begin
    if (s3_ld) begin
      out_dat <= s2_ovf ? sat_val : s2_sum[OUT_W-1:0];
    end
  end

  // output held while the sink stalls
  a_out_stable: assert property (
    @(posedge sti) disable iff (rst)
    out_vld && !out_rdy |=> out_vld && $stable(out_dat)
  );

  // nothing leaves the pipe until a sample has refilled all three stages
  a_out_idle_after_rst: assert property (
    @(posedge sti)
    rst |=> !out_vld [*3]
  );

endmodule

`default_nettype wire

/* hw/lin_top.sv */
// gain/offset stage top level
// register block beside the three-stage transform pipeline

`default_nettype none

module lin_top (
  input  wire                       sti,
  input  wire                       rst,
  // input stream
  input  wire lin_pkg::sample_in_t  in_dat,
  input  wire                       in_vld,
  output logic                      in_rdy,
  // output stream
  output lin_pkg::sample_out_t      out_dat,
  output logic                      out_vld,
  input  wire                       out_rdy,
  // register port
  input  wire                       reg_we,
  input  wire lin_pkg::reg_addr_t   reg_addr,
  input  wire lin_pkg::reg_dat_t    reg_wdat,
  output lin_pkg::reg_dat_t         reg_rdat
);

  import lin_pkg::*;

  gain_t   cfg_gain;  // registered coefficients
  offset_t cfg_ofs;
  logic    sat_evt;   // clip pulse back to the counter

  lin_regs i_regs (
    .sti      (sti),
    .rst      (rst),
    .reg_we   (reg_we),
    .reg_addr (reg_addr),
    .reg_wdat (reg_wdat),
    .reg_rdat (reg_rdat),
    .cfg_gain (cfg_gain),
    .cfg_ofs  (cfg_ofs),
    .sat_evt  (sat_evt)
  );

  lin_xform i_xform (
    .sti      (sti),
    .rst      (rst),
    .in_dat   (in_dat),
    .in_vld   (in_vld),
    .in_rdy   (in_rdy),
    .out_dat  (out_dat),
    .out_vld  (out_vld),
    .out_rdy  (out_rdy),
    .cfg_gain (cfg_gain),
    .cfg_ofs  (cfg_ofs),
    .sat_evt  (sat_evt)
  );

endmodule

`default_nettype wire

/* testbench/lin_tb.sv */
// gain/offset stage testbench
// replays testbench/lin_tests.txt against lin_top, models each output
// and checks streams and registers

`default_nettype none

`include "lin_consts.svh"

module lin_tb;

  import lin_pkg::*;

  localparam int HALF = 50;        // half clock period
  localparam int QTR  = HALF / 2;  // settle point after the falling edge
  localparam int TMO  = 1000;      // per-wait limit in cycles

  logic sti, rst, in_vld, in_rdy, out_vld, out_rdy, reg_we;
  sample_in_t  in_dat;
  sample_out_t out_dat;
  reg_addr_t   reg_addr;
  reg_dat_t    reg_wdat, reg_rdat;

  gain_t       m_gain;             // model copy of the coefficients
  offset_t     m_ofs;
  sample_in_t  s_in[$];            // pending burst
  sample_out_t s_exp[$];
  bit          bp;                 // random out_rdy when set
  int          cyc = 0;            // rising edges since start
  int          first_in, first_out;
  int          errors = 0;
  int          checks = 0;

  lin_top i_dut (
    .sti(sti), .rst(rst),
    .in_dat(in_dat), .in_vld(in_vld), .in_rdy(in_rdy),
    .out_dat(out_dat), .out_vld(out_vld), .out_rdy(out_rdy),
    .reg_we(reg_we), .reg_addr(reg_addr), .reg_wdat(reg_wdat), .reg_rdat(reg_rdat)
  );

  initial sti = 1'b0;
  always #HALF sti = ~sti;
  always @(posedge sti) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // model and checks
  //////////////////////////////////////////////////

  // sat(floor(x * gain / 2^14) + offset)
  function automatic sample_out_t model_out(input sample_in_t x);
    longint p;
    longint q;
    p = longint'(x) * longint'(m_gain);
    q = p / (64'sd1 << (`LIN_GAIN_W - 2));
    if (p < 0 && q * (64'sd1 << (`LIN_GAIN_W - 2)) != p) q = q - 1;  // toward -inf
    q = q + longint'(m_ofs);
    if (q > 8191) q = 8191;
    else if (q < -8192) q = -8192;
    return sample_out_t'(q);
  endfunction

  task automatic check_sample(input string sig, input sample_out_t exp, input sample_out_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %0d got %0d", $time, sig, exp, got);
    end
  endtask

  task automatic check_reg(input string sig, input reg_dat_t exp, input reg_dat_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected 0x%08h got 0x%08h", $time, sig, exp, got);
    end
  endtask

  task automatic check_flag(input string sig, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %b got %b", $time, sig, exp, got);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $finish;
  endtask

  //////////////////////////////////////////////////
  // register port, all start and end on a falling edge
  //////////////////////////////////////////////////

  task automatic write_reg(input int addr, input int data);
    reg_we   = 1'b1;
    reg_addr = reg_addr_t'(addr);
    reg_wdat = reg_dat_t'(data);
    if (addr == `LIN_ADDR_GAIN) m_gain = gain_t'(data);  // low bits only
    if (addr == `LIN_ADDR_OFS) m_ofs = offset_t'(data);
    @(negedge sti);
    reg_we = 1'b0;
  endtask

  task automatic read_reg(input int addr, input int exp);
    reg_addr = reg_addr_t'(addr);
    #(QTR);  // combinational read
    check_reg($sformatf("reg_rdat[%0d]", addr), reg_dat_t'(exp), reg_rdat);
    @(negedge sti);
  endtask

  task automatic queue_sample(input int x, input int exp);
    sample_out_t m;
    m = model_out(sample_in_t'(x));
    if (m !== sample_out_t'(exp)) begin
      errors++;
      $display("test file expects %0d for input %0d but the model gives %0d", exp, x, m);
    end
    s_in.push_back(sample_in_t'(x));
    s_exp.push_back(sample_out_t'(exp));
  endtask

  //////////////////////////////////////////////////
  // stream driver and monitor
  //////////////////////////////////////////////////

  task automatic drive_samples();
    int n;
    for (int i = 0; i < s_in.size(); i++) begin
      if (bp) repeat ($urandom_range(2)) @(negedge sti);  // idle gap
      in_dat = s_in[i];
      in_vld = 1'b1;
      #(QTR);
      n = 0;
      while (!in_rdy && n < TMO) begin
        @(negedge sti);
        #(QTR);
        n++;
      end
      if (!in_rdy) abort_run("timeout, in_rdy stayed low for 1000 cycles");
      if (i == 0) first_in = cyc;  // cycle that carries the transfer
      @(negedge sti);
      in_vld = 1'b0;
    end
  endtask

  task automatic collect_samples();
    int k;
    int idle;
    k = 0;
    idle = 0;
    while (k < s_exp.size() && idle < TMO) begin
      out_rdy = bp ? ($urandom_range(3) != 0) : 1'b1;
      #(QTR);
      if (out_vld && first_out < 0) first_out = cyc;  // loaded on this edge
      if (out_vld && out_rdy) begin
        check_sample("out_dat", s_exp[k], out_dat);
        k++;
        idle = 0;
      end else begin
        idle++;
      end
      if (k < s_exp.size()) @(negedge sti);
    end
    if (k < s_exp.size()) abort_run("timeout, out_vld stayed low for 1000 cycles");
  endtask

  task automatic run_burst();
    first_in  = -1;
    first_out = -1;
    fork
      drive_samples();
      collect_samples();
    join
    @(negedge sti);
    out_rdy = 1'b1;
    if (!bp && first_out - first_in != 3) begin
      errors++;
      $display("first output came %0d cycles after the first transfer, not 3",
               first_out - first_in);
    end
    s_in.delete();
    s_exp.delete();
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int fd, a, b, test_err, n_tests, n_failed;
    string line, rest, name;
    byte cmd;
    void'($urandom(42260));
    rst = 1'b1;
    in_dat = '0;
    in_vld = 1'b0;
    out_rdy = 1'b1;
    reg_we = 1'b0;
    reg_addr = '0;
    reg_wdat = '0;
    m_gain = gain_t'(`LIN_GAIN_RST);
    m_ofs = offset_t'(`LIN_OFS_RST);
    bp = 1'b0;
    n_tests = 0;
    n_failed = 0;
    test_err = 0;
    repeat (8) @(posedge sti);
    @(negedge sti);
    rst = 1'b0;
    #(QTR);
    check_flag("out_vld", 1'b0, out_vld);  // empty pipe
    check_flag("in_rdy", 1'b1, in_rdy);
    @(negedge sti);
    fd = $fopen("testbench/lin_tests.txt", "r");
    if (fd == 0) abort_run("cannot open testbench/lin_tests.txt");
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        cmd = line.getc(0);
        rest = line.substr(1, line.len() - 1);
        a = 0;
        b = 0;
        if (cmd != "S" && s_in.size() > 0) run_burst();  // flush queued samples
        if (cmd != "T") void'($sscanf(rest, "%d %d", a, b));
        case (cmd)
          "T": begin
            void'($sscanf(rest, "%s", name));
            test_err = errors;
          end
          "W": write_reg(a, b);
          "R": read_reg(a, b);
          "B": bp = (a != 0);
          "S": queue_sample(a, b);
          "E": begin
            n_tests++;
            if (errors > test_err) n_failed++;
            $display("test %s finished with %0d errors", name, errors - test_err);
          end
          default: begin
            errors++;
            $display("unknown command in test file: %s", line);
          end
        endcase
      end
    end
    $fclose(fd);
    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             n_tests, n_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* lin_top.f */
+incdir+hw
hw/lin_pkg.sv
hw/lin_regs.sv
hw/lin_xform.sv
hw/lin_top.sv
testbench/lin_tb.sv

/* Bender.yml */
package:
  name: lin_top

sources:
  - include_dirs:
      - hw
    files:
      - hw/lin_pkg.sv
      - hw/lin_regs.sv
      - hw/lin_xform.sv
      - hw/lin_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/lin_tb.sv

/* testbench/lin_tests.txt */
# T name | W addr data | R addr expected | B 1 for random out_rdy, 0 for always ready
# S input expected (decimal), queued samples run before the next other command | E end
T reset_values
R 0 16384
R 1 0
R 2 0
E
T unity_burst
B 0
S 0 0
S 1 1
S -1 -1
S 8191 8191
S -8192 -8192
E
T gain_offset
W 0 8192
W 1 -100
R 1 -100
S 3 -99
S -3 -102
S 8191 3995
W 0 -24576
W 1 37
S 1 35
S -5 44
S 1000 -1463
E
T saturate
W 0 32767
W 1 4000
S 4000 8191
S -4000 -4000
S 2200 8191
S -7000 -8192
R 2 3
E
T random_flow
W 0 16384
W 1 -10
B 1
S 10 0
S 20 10
S -30 -40
S -8190 -8192
S 5000 4990
S 7 -3
E
T count_clear
W 2 0
R 2 0
W 1 8000
S 1000 8191
S -100 7900
S 500 8191
R 2 2
E
